// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= sifhTb
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== bench/sifhTb.sv ====
module sifhTb import sifhPkg::*; ();

    // one row word as predicted by the model.
    typedef struct packed {
        rowWordT     word;
        rowT         row;
        acqT         acq;
        logic        sat;
        logic [31:0] cycle;
    } expRowT;

    logic        clk;
    logic        rstN;
    logic        wrEn;
    sampleT      data;
    logic        clrHist;
    logic        resultValid;
    rowWordT     result;
    rowT         resultRow;
    acqT         resultAcq;
    logic        resultSat;

    expRowT      expQ[$];
    int          modelCount [ROW_NUM][PIXEL_NUM_PER_RAM];
    int          modelRow;
    int          modelCol;
    int          modelAcq;
    logic [31:0] rngState;
    logic [31:0] cycleCount = '0;
    int          errCount = 0;
    int          rowsChecked = 0;
    int          testCount = 0;
    int          testErrStart;
    int          testRowStart;

    sifhTop i_sifhTop (
        .clk         (clk),
        .rstN        (rstN),
        .wrEn        (wrEn),
        .data        (data),
        .clrHist     (clrHist),
        .resultValid (resultValid),
        .result      (result),
        .resultRow   (resultRow),
        .resultAcq   (resultAcq),
        .resultSat   (resultSat)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic sampleT randomSample();
        rngState = xorshift32(rngState);
        return rngState[Np-1:0];
    endfunction

    function automatic int totalErrors();
        return errCount + i_sifhTop.i_sifhTb_asserts.failCount;
    endfunction

    // clipped difference, threshold and saturation, then the row word on the last column.
    task automatic predictPixel(input sampleT rst, input sampleT sig, input logic [31:0] lastCyc);
        int     cds;
        expRowT e;
        cds = (sig > rst) ? int'(sig) - int'(rst) : 0;
        if (cds >= HIT_THRESHOLD && modelCount[modelRow][modelCol] < int'(COUNT_MAX)) begin
            modelCount[modelRow][modelCol]++;
        end
        if (modelCol == PIXEL_NUM_PER_RAM - 1) begin
            e.sat = 1'b0;
            for (int c = 0; c < PIXEL_NUM_PER_RAM; c++) begin
                e.word[c*Np +: Np] = countT'(modelCount[modelRow][c]);
                if (modelCount[modelRow][c] == int'(COUNT_MAX)) begin
                    e.sat = 1'b1;
                end
            end
            e.row   = rowT'(modelRow);
            e.acq   = acqT'(modelAcq);
            e.cycle = lastCyc;
            expQ.push_back(e);
            modelCol = 0;
            if (modelRow == ROW_NUM - 1) begin
                modelRow = 0;
                modelAcq = (modelAcq + 1) % 256;
            end else begin
                modelRow++;
            end
        end else begin
            modelCol++;
        end
    endtask

    task automatic driveSample(input sampleT value);
        @(posedge clk);
        wrEn <= 1'b1;
        data <= value;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            wrEn <= 1'b0;
        end
    endtask

    // gaps, when enabled, are idle cycles picked at random.
    task automatic sendPixel(input sampleT rst, input sampleT sig, input bit gaps);
        sampleT r;
        driveSample(rst);
        r = randomSample();
        if (gaps && r[0]) begin
            idleCycles(1);
        end
        driveSample(sig);
        // the signal sample is on the bus in the next cycle.
        predictPixel(rst, sig, cycleCount + 1);
        if (gaps && r[1]) begin
            idleCycles(1);
        end
    endtask

    task automatic sendRandomPixels(input int n, input bit gaps);
        sampleT r;
        sampleT s;
        for (int p = 0; p < n; p++) begin
            r = randomSample();
            s = randomSample();
            sendPixel(r, s, gaps);
        end
    endtask

    task automatic clearHistogram();
        @(posedge clk);
        wrEn    <= 1'b0;
        clrHist <= 1'b1;
        @(posedge clk);
        clrHist <= 1'b0;
        modelCount = '{default: '{default: 0}};
        modelAcq   = 0;
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (expQ.size() != 0 && waited < 200) begin
            @(posedge clk);
            waited++;
        end
        if (expQ.size() != 0) begin
            $display("timeout: %0d row words never came out after %0d cycles",
                     expQ.size(), waited);
            $display("ERRORS FOUND");
            $finish;
        end
    endtask

    task automatic startTest();
        testErrStart = totalErrors();
        testRowStart = rowsChecked;
    endtask

    task automatic finishTest(input string name);
        testCount++;
        $display("test %0d %s: %0d row words checked, %0d mismatches", testCount, name,
                 rowsChecked - testRowStart, totalErrors() - testErrStart);
    endtask

    // every row word is checked against the oldest prediction.
    always @(negedge clk) begin
        expRowT e;
        if (rstN && resultValid) begin
            if (expQ.size() == 0) begin
                $display("row word at %0t came out with none predicted", $time);
                errCount++;
            end else begin
                e = expQ.pop_front();
                rowsChecked++;
                assert (result == e.word) else begin
                    $display("FAIL %0t result expected %h got %h", $time, e.word, result);
                    errCount++;
                end
                assert (resultRow == e.row) else begin
                    $display("FAIL %0t resultRow expected %0d got %0d", $time, e.row, resultRow);
                    errCount++;
                end
                assert (resultAcq == e.acq) else begin
                    $display("FAIL %0t resultAcq expected %0d got %0d", $time, e.acq, resultAcq);
                    errCount++;
                end
                assert (resultSat == e.sat) else begin
                    $display("FAIL %0t resultSat expected %0b got %0b", $time, e.sat, resultSat);
                    errCount++;
                end
                assert (cycleCount - e.cycle == 3) else begin
                    $display("FAIL %0t resultValid latency expected 3 got %0d", $time,
                             cycleCount - e.cycle);
                    errCount++;
                end
            end
        end
    end

    initial begin
        int total;
        // samples strobed during reset must be ignored.
        rstN       <= 1'b0;
        wrEn       <= 1'b1;
        data       <= '0;
        clrHist    <= 1'b0;
        rngState   = 32'h901227e7;
        modelCount = '{default: '{default: 0}};
        modelRow   = 0;
        modelCol   = 0;
        modelAcq   = 0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        wrEn <= 1'b0;
        idleCycles(2);

        // hits on row 0 col 0, row 1 col 0 and col 1.
        startTest();
        sendPixel(10'd108, 10'd511, 1'b0);
        sendPixel(10'd200, 10'd90, 1'b0);
        sendPixel(10'd300, 10'd399, 1'b0);
        sendPixel(10'd0, 10'd100, 1'b0);
        sendPixel(10'd512, 10'd1023, 1'b0);
        sendPixel(10'd1023, 10'd0, 1'b0);
        idleCycles(1);
        waitDrain();
        finishTest("directed hits");

        startTest();
        sendRandomPixels(20 * ROW_NUM * PIXEL_NUM_PER_RAM, 1'b1);
        idleCycles(1);
        waitDrain();
        finishTest("random accumulation");

        // only row 1 col 1 ever hits.
        startTest();
        clearHistogram();
        repeat (1030) begin
            for (int p = 0; p < ROW_NUM * PIXEL_NUM_PER_RAM; p++) begin
                if (p == 4) begin
                    sendPixel(10'd0, 10'd1000, 1'b0);
                end else begin
                    sendPixel(10'd500, 10'd400, 1'b0);
                end
            end
        end
        idleCycles(1);
        waitDrain();
        finishTest("saturation");

        // clear after row 0 and the first pixel of row 1.
        startTest();
        sendRandomPixels(PIXEL_NUM_PER_RAM + 1, 1'b1);
        idleCycles(1);
        waitDrain();
        idleCycles(3);
        clearHistogram();
        sendRandomPixels(PIXEL_NUM_PER_RAM - 1 + 2 * ROW_NUM * PIXEL_NUM_PER_RAM, 1'b1);
        idleCycles(1);
        waitDrain();
        finishTest("clear mid acquisition");

        startTest();
        sendRandomPixels(3 * ROW_NUM * PIXEL_NUM_PER_RAM, 1'b0);
        idleCycles(1);
        waitDrain();
        finishTest("back to back");

        idleCycles(4);
        total = totalErrors();
        $display("tests run %0d, row words checked %0d, mismatches %0d",
                 testCount, rowsChecked, total);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== bench/sifhTb_asserts.sv ====
module sifhTb_asserts import sifhPkg::*; (
    input logic clk,
    input logic rstN,
    input logic wrEn,
    input logic clrHist,
    input logic pixValid,
    input logic rowValid,
    input logic resultValid,
    input acqT  resultAcq
);

    // read by the testbench at the end of the run.
    int   failCount = 0;

    // sample phase, tracked apart from the framer.
    logic signalPhase;

    // a clear happened and no row word has left since.
    logic clearPending;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            signalPhase <= 1'b0;
        end else if (wrEn) begin
            signalPhase <= ~signalPhase;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            clearPending <= 1'b0;
        end else if (clrHist) begin
            clearPending <= 1'b1;
        end else if (resultValid) begin
            clearPending <= 1'b0;
        end
    end

    pixAfterSignal: assert property (@(posedge clk) disable iff (!rstN)
        wrEn && signalPhase |=> pixValid)
    else begin
        $error("pixValid missing one cycle after a signal sample");
        failCount++;
    end

    pixOnlyAfterSignal: assert property (@(posedge clk) disable iff (!rstN)
        pixValid |-> $past(wrEn && signalPhase))
    else begin
        $error("pixValid without a signal sample in the cycle before");
        failCount++;
    end

    resultAfterRow: assert property (@(posedge clk) disable iff (!rstN)
        rowValid |=> resultValid)
    else begin
        $error("resultValid missing one cycle after rowValid");
        failCount++;
    end

    resultOnlyAfterRow: assert property (@(posedge clk) disable iff (!rstN)
        resultValid |-> $past(rowValid))
    else begin
        $error("resultValid without rowValid in the cycle before");
        failCount++;
    end

    strobesLowInReset: assert property (@(posedge clk)
        !rstN |-> !(pixValid || rowValid || resultValid))
    else begin
        $error("a strobe is high while reset is asserted");
        failCount++;
    end

    strobesLowAfterReset: assert property (@(posedge clk)
        $rose(rstN) |-> !(pixValid || rowValid || resultValid))
    else begin
        $error("a strobe is high in the first cycle after reset");
        failCount++;
    end

    acqZeroAfterClear: assert property (@(posedge clk) disable iff (!rstN)
        resultValid && clearPending |-> resultAcq == '0)
    else begin
        $error("first row word after a clear is not tagged acquisition 0");
        failCount++;
    end

endmodule

bind sifhTop sifhTb_asserts i_sifhTb_asserts (
    .clk         (clk),
    .rstN        (rstN),
    .wrEn        (wrEn),
    .clrHist     (clrHist),
    .pixValid    (pixValid),
    .rowValid    (rowValid),
    .resultValid (resultValid),
    .resultAcq   (resultAcq)
);

// ==== logic/hisBuilderFSM.sv ====
module hisBuilderFSM import sifhPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     clrHist,
    input  logic     pixValid,
    input  pixelRecT pixRec,
    output logic     rowValid,
    output rowOutT   rowOut
);

    // idle means every count is known to be zero.
    typedef enum logic {
        IDLE,
        ACCUM
    } hisStateT;

    hisStateT state;
    hisStateT nextState;

    // the histogram itself.
    countT   counts [ROW_NUM][PIXEL_NUM_PER_RAM];

    // count of the addressed pixel before and after this record.
    countT   curCount;
    countT   nextCount;

    // the addressed row with the update already applied.
    rowWordT rowWord;

    logic    takePixel;
    logic    lastCol;
    logic    lastRow;

    // a clear in the same cycle drops the pixel.
    assign takePixel = pixValid && !clrHist;

    assign lastCol = (pixRec.col == colT'(PIXEL_NUM_PER_RAM - 1));
    assign lastRow = (pixRec.row == rowT'(ROW_NUM - 1));

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (takePixel) begin
                    nextState = ACCUM;
                end
            end
            ACCUM: begin
                if (clrHist) begin
                    nextState = IDLE;
                end
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // nothing has been counted yet while idle.
    always_comb begin
        if (state == IDLE) begin
            curCount = '0;
        end else begin
            curCount = counts[pixRec.row][pixRec.col];
        end
    end

    // saturating increment on a hit.
    always_comb begin
        nextCount = curCount;
        if (pixRec.hit && (curCount != COUNT_MAX)) begin
            nextCount = curCount + 1'b1;
        end
    end

    // pack the row, substituting the fresh count.
    always_comb begin
        for (int c = 0; c < PIXEL_NUM_PER_RAM; c++) begin
            if (pixRec.col == colT'(c)) begin
                rowWord[c*Np +: Np] = nextCount;
            end else begin
                rowWord[c*Np +: Np] = counts[pixRec.row][c];
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            counts <= '{default: '{default: '0}};
        end else if (clrHist) begin
            counts <= '{default: '{default: '0}};
        end else if (pixValid) begin
            counts[pixRec.row][pixRec.col] <= nextCount;
        end
    end

    // row word leaves one cycle after the last column.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rowValid <= 1'b0;
        end else begin
            rowValid <= takePixel && lastCol;
        end
    end

    always_ff @(posedge clk) begin
        if (takePixel && lastCol) begin
            rowOut.row     <= pixRec.row;
            rowOut.word    <= rowWord;
            rowOut.lastRow <= lastRow;
        end
    end

endmodule

// ==== logic/histReadout.sv ====
module histReadout import sifhPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    clrHist,
    input  logic    rowValid,
    input  rowOutT  rowOut,
    output logic    resultValid,
    output rowWordT result,
    output rowT     resultRow,
    output acqT     resultAcq,
    output logic    resultSat
);

    // acquisitions completed since reset or clear.
    acqT  acq;

    // some pixel of the incoming row is pinned at max.
    logic rowSat;

    always_comb begin
        rowSat = 1'b0;
        for (int p = 0; p < PIXEL_NUM_PER_RAM; p++) begin
            if (rowOut.word[p*Np +: Np] == COUNT_MAX) begin
                rowSat = 1'b1;
            end
        end
    end

    // clear wins over the end of an acquisition.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            acq <= '0;
        end else if (clrHist) begin
            acq <= '0;
        end else if (rowValid && rowOut.lastRow) begin
            acq <= acq + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resultValid <= 1'b0;
            resultAcq   <= '0;
        end else begin
            resultValid <= rowValid;
            if (rowValid) begin
                // a row caught by a clear is already tagged as acquisition 0.
                resultAcq <= clrHist ? acqT'(0) : acq;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rowValid) begin
            result    <= rowOut.word;
            resultRow <= rowOut.row;
            resultSat <= rowSat;
        end
    end

endmodule

// ==== logic/sampleFramer.sv ====
module sampleFramer import sifhPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     wrEn,
    input  sampleT   data,
    output logic     pixValid,
    output pixelRecT pixRec
);

    // sample phase within a pixel.
    // low while waiting for the reset sample.
    logic   secondSample;

    // position of the pixel being sampled.
    colT    col;
    rowT    row;

    // reset level held until the signal level arrives.
    sampleT resetSample;

    // clipped difference and hit decision.
    sampleT cds;
    logic   hit;

    logic   lastCol;
    logic   lastRow;

    assign lastCol = (col == colT'(PIXEL_NUM_PER_RAM - 1));
    assign lastRow = (row == rowT'(ROW_NUM - 1));

    // signal below reset gives no charge, so clip at zero.
    always_comb begin
        if (data > resetSample) begin
            cds = data - resetSample;
        end else begin
            cds = '0;
        end
        hit = (cds >= sampleT'(HIT_THRESHOLD));
    end

    // phase and position only move on a sample strobe.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            secondSample <= 1'b0;
            col          <= '0;
            row          <= '0;
        end else if (wrEn) begin
            secondSample <= ~secondSample;
            if (secondSample) begin
                if (lastCol) begin
                    col <= '0;
                    if (lastRow) begin
                        row <= '0;
                    end else begin
                        row <= row + 1'b1;
                    end
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // capture the reset level on the first sample.
    always_ff @(posedge clk) begin
        if (wrEn && !secondSample) begin
            resetSample <= data;
        end
    end

    // record strobe, one cycle after the signal sample.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pixValid <= 1'b0;
        end else begin
            pixValid <= wrEn && secondSample;
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn && secondSample) begin
            pixRec.row <= row;
            pixRec.col <= col;
            pixRec.cds <= cds;
            pixRec.hit <= hit;
        end
    end

endmodule

// ==== logic/sifhPkg.sv ====
package sifhPkg;

    // sample and hit count width.
    localparam int Np = 10;

    // sensor geometry per acquisition.
    localparam int PIXEL_NUM_PER_RAM = 3;
    localparam int ROW_NUM = 2;

    // minimum cds value that is counted as a hit.
    localparam int HIT_THRESHOLD = 100;

    // counts stick here once reached.
    localparam logic [Np-1:0] COUNT_MAX = {Np{1'b1}};

    // one raw adc sample.
    typedef logic [Np-1:0] sampleT;

    // one saturating per-pixel hit count.
    typedef logic [Np-1:0] countT;

    // pixel index within a row.
    typedef logic [1:0] colT;

    // row index within an acquisition.
    typedef logic [0:0] rowT;

    // acquisition number, wraps at 256.
    typedef logic [7:0] acqT;

    // one row of counts, pixel 0 in the low bits.
    typedef logic [PIXEL_NUM_PER_RAM*Np-1:0] rowWordT;

    // one paired pixel, as produced by the framer.
    typedef struct packed {
        rowT    row;
        colT    col;
        sampleT cds;
        logic   hit;
    } pixelRecT;

    // one finished row of the histogram.
    typedef struct packed {
        rowT     row;
        rowWordT word;
        logic    lastRow;
    } rowOutT;

endpackage

// ==== logic/sifhTop.sv ====
module sifhTop import sifhPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    wrEn,
    input  sampleT  data,
    input  logic    clrHist,
    output logic    resultValid,
    output rowWordT result,
    output rowT     resultRow,
    output acqT     resultAcq,
    output logic    resultSat
);

    // framer to histogram builder.
    logic     pixValid;
    pixelRecT pixRec;

    // histogram builder to readout.
    logic     rowValid;
    rowOutT   rowOut;

    sampleFramer i_sampleFramer (
        .clk      (clk),
        .rstN     (rstN),
        .wrEn     (wrEn),
        .data     (data),
        .pixValid (pixValid),
        .pixRec   (pixRec)
    );

    hisBuilderFSM i_hisBuilderFSM (
        .clk      (clk),
        .rstN     (rstN),
        .clrHist  (clrHist),
        .pixValid (pixValid),
        .pixRec   (pixRec),
        .rowValid (rowValid),
        .rowOut   (rowOut)
    );

    // registers the row word and tags it.
    histReadout i_histReadout (
        .clk         (clk),
        .rstN        (rstN),
        .clrHist     (clrHist),
        .rowValid    (rowValid),
        .rowOut      (rowOut),
        .resultValid (resultValid),
        .result      (result),
        .resultRow   (resultRow),
        .resultAcq   (resultAcq),
        .resultSat   (resultSat)
    );

endmodule

// ==== project.f ====
logic/sifhPkg.sv
logic/sampleFramer.sv
logic/hisBuilderFSM.sv
logic/histReadout.sv
logic/sifhTop.sv
bench/sifhTb_asserts.sv
bench/sifhTb.sv
